/* build.f */
+incdir+design
design/apb_sub_pkg.sv
design/apb_if.sv
design/apb_bus.sv
design/apb_scratch_regs.sv
design/apb_gpio.sv
design/apb_sub_top.sv
test/apb_sub_tb.sv

/* run.sh */
#!/bin/sh
# compile the APB subsystem testbench with Verilator, run it and grade the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module apb_sub_tb -o apb_sub_sim
./obj_dir/apb_sub_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
  exit 0
else
  exit 1
fi

/* test/apb_sub_stimulus.txt */
// grp op addr wdata strb gpio_in exp_rdata exp_slverr exp_gpio_o exp_gpio_oe exp_cycles
// op 1 is a write, exp_rdata is checked on reads only, exp_cycles counts access cycles
1 0 00000000 00000000 0 0000 00000000 0 0000 0000 1
1 0 00000004 00000000 0 0000 00000000 0 0000 0000 1
1 0 00000008 00000000 0 0000 00000000 0 0000 0000 1
1 0 0000000c 00000000 0 0000 00000000 0 0000 0000 1
1 0 00001000 00000000 0 0000 00000000 0 0000 0000 2
2 1 00000000 11223344 f 0000 00000000 0 0000 0000 1
2 1 00000004 55667788 f 0000 00000000 0 0000 0000 1
2 1 00000008 99aabbcc f 0000 00000000 0 0000 0000 1
2 1 0000000c ddeeff00 f 0000 00000000 0 0000 0000 1
2 0 00000000 00000000 0 0000 11223344 0 0000 0000 1
2 0 00000004 00000000 0 0000 55667788 0 0000 0000 1
2 0 00000008 00000000 0 0000 99aabbcc 0 0000 0000 1
2 0 0000000c 00000000 0 0000 ddeeff00 0 0000 0000 1
2 1 00000004 a1b2c3d4 5 0000 00000000 0 0000 0000 1
2 0 00000004 00000000 0 0000 55b277d4 0 0000 0000 1
3 1 00001000 00ffa5a5 f 0000 00000000 0 a5a5 00ff 2
3 1 00001000 f0f01234 c 0000 00000000 0 a5a5 f0f0 2
3 0 00001000 00000000 0 0000 f0f0a5a5 0 a5a5 f0f0 2
4 0 00001004 00000000 0 3c5a 00003c5a 0 a5a5 f0f0 2
4 1 00001004 ffffffff f 8001 00000000 1 a5a5 f0f0 2
4 0 00001004 00000000 0 8001 00008001 0 a5a5 f0f0 2
4 0 00001000 00000000 0 8001 f0f0a5a5 0 a5a5 f0f0 2
5 1 00000010 deadbeef f 0000 00000000 1 a5a5 f0f0 1
5 0 00000fff 00000000 0 0000 00000000 1 a5a5 f0f0 1
5 1 00001008 deadbeef f 0000 00000000 1 a5a5 f0f0 1
5 0 00001008 00000000 0 0000 00000000 1 a5a5 f0f0 1
5 0 00000000 00000000 0 0000 11223344 0 a5a5 f0f0 1
5 0 00001000 00000000 0 0000 f0f0a5a5 0 a5a5 f0f0 2
6 0 0000000f 00000000 0 0000 ddeeff00 0 a5a5 f0f0 1
6 0 00001007 00000000 0 0f0f 00000f0f 0 a5a5 f0f0 2
6 1 00001000 12345678 3 0f0f 00000000 0 5678 f0f0 2
6 0 00001003 00000000 0 0f0f f0f05678 0 5678 f0f0 2

/* test/apb_sub_tb.sv */
//////////////////////////////////////////////////////////////////////
// APB subsystem testbench, transfers and expected results from a data file
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "apb_sub_macros.svh"

module apb_sub_tb;

  localparam int n_fields = 11;
  localparam int max_recs = 64;
  localparam int ready_timeout = 20;

  logic                   pclk_i;
  logic                   rst_n_i;
  logic [`APB_ADDR_W-1:0] paddr_i;
  logic [2:0]             pprot_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`APB_DATA_W-1:0] pwdata_i;
  logic [`APB_STRB_W-1:0] pstrb_i;
  logic                   pready_o;
  logic [`APB_DATA_W-1:0] prdata_o;
  logic                   pslverr_o;
  logic [`GPIO_W-1:0]     gpio_i;
  logic [`GPIO_W-1:0]     gpio_o;
  logic [`GPIO_W-1:0]     gpio_oe_o;

  // flat record memory, n_fields words per transaction
  logic [31:0]            stim_mem [n_fields*max_recs];
  logic [31:0]            rd_data;
  logic                   rd_err;
  int                     acc_cycles;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     grp_fails;
  bit                     timed_out;

  apb_sub_top dut_i (
    .pclk_i    (pclk_i),
    .rst_n_i   (rst_n_i),
    .paddr_i   (paddr_i),
    .pprot_i   (pprot_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  always #5 pclk_i = ~pclk_i;

  function automatic string group_name(input int grp);
    case (grp)
      1: return "reset state";
      2: return "scratch byte strobes";
      3: return "gpio configuration union";
      4: return "gpio input";
      5: return "decode error";
      6: return "offsets and wait states";
      default: return "unnamed group";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("error: t=%0t %s expected %h got %h", $time, name, exp, act);
    fail_cnt++;
    grp_fails++;
  endtask

  task automatic report_group(input int grp);
    if (grp_fails == 0) $display("test %0d %s: ok", grp, group_name(grp));
    else $display("test %0d %s: %0d checks wrong", grp, group_name(grp), grp_fails);
  endtask

  // one APB transfer, setup then access phase, all driven on falling edges
  // response is sampled mid-cycle, before the rising edge that completes it
  task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb);
    bit got_ready;
    @(negedge pclk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pstrb_i   = strb;
    @(negedge pclk_i);
    penable_i  = 1'b1;
    acc_cycles = 0;
    got_ready  = 1'b0;
    while (!got_ready && acc_cycles < ready_timeout) begin
      #2;
      acc_cycles++;
      if (pready_o) begin
        got_ready = 1'b1;
        rd_data   = prdata_o;
        rd_err    = pslverr_o;
      end
      @(negedge pclk_i);
    end
    // back to idle, one cycle after the completing edge
    psel_i    = 1'b0;
    penable_i = 1'b0;
    timed_out = !got_ready;
  endtask

  initial begin
    int rec;
    int base;
    int cur_grp;
    pclk_i = 1'b0;
    rst_n_i = 1'b0;
    paddr_i = '0;
    pprot_i = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    pwdata_i = '0;
    pstrb_i = '0;
    gpio_i = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    grp_fails = 0;
    timed_out = 1'b0;
    // all ones in the group column marks the end of the records
    for (int i = 0; i < n_fields*max_recs; i++) stim_mem[i] = '1;
    $readmemh("test/apb_sub_stimulus.txt", stim_mem);
    repeat (16) @(negedge pclk_i);
    rst_n_i = 1'b1;
    @(negedge pclk_i);
    // an idle bus must not answer
    if (pready_o !== 1'b0) report_mismatch("pready_o", 32'd0, pready_o);
    else pass_cnt++;
    if (pslverr_o !== 1'b0) report_mismatch("pslverr_o", 32'd0, pslverr_o);
    else pass_cnt++;
    cur_grp = 1;
    rec = 0;
    while (!timed_out && rec < max_recs && stim_mem[rec*n_fields] != 32'hffff_ffff) begin
      base = rec*n_fields;
      if (int'(stim_mem[base]) != cur_grp) begin
        report_group(cur_grp);
        cur_grp = stim_mem[base];
        grp_fails = 0;
      end
      // let the new pin value pass the synchronizer before the transfer
      gpio_i = stim_mem[base+5][`GPIO_W-1:0];
      repeat (3) @(negedge pclk_i);
      apb_transfer(stim_mem[base+1][0], stim_mem[base+2], stim_mem[base+3], stim_mem[base+4][3:0]);
      if (timed_out) begin
        $display("transfer %0d to address %h got no pready within %0d cycles",
                 rec, stim_mem[base+2], ready_timeout);
        fail_cnt++;
        grp_fails++;
      end else begin
        if (stim_mem[base+1][0] == 1'b0) begin
          if (rd_data !== stim_mem[base+6]) report_mismatch("prdata_o", stim_mem[base+6], rd_data);
          else pass_cnt++;
        end
        if (rd_err !== stim_mem[base+7][0]) report_mismatch("pslverr_o", stim_mem[base+7], rd_err);
        else pass_cnt++;
        if (acc_cycles != int'(stim_mem[base+10])) begin
          report_mismatch("access cycles", stim_mem[base+10], acc_cycles);
        end else begin
          pass_cnt++;
        end
        // pins are sampled in the cycle after the completing edge
        if (gpio_o !== stim_mem[base+8][`GPIO_W-1:0]) report_mismatch("gpio_o", stim_mem[base+8], gpio_o);
        else pass_cnt++;
        if (gpio_oe_o !== stim_mem[base+9][`GPIO_W-1:0]) begin
          report_mismatch("gpio_oe_o", stim_mem[base+9], gpio_oe_o);
        end else begin
          pass_cnt++;
        end
      end
      rec++;
    end
    if (rec == 0) begin
      $display("no transactions were read from the stimulus file");
      fail_cnt++;
    end
    report_group(cur_grp);
    $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* design/apb_sub_top.sv */
//////////////////////////////////////////////////////////////////////
// APB subsystem top: bus decoder with scratch bank and GPIO slaves
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "apb_sub_macros.svh"

module apb_sub_top
  import apb_sub_pkg::*;
(
  input  logic                   pclk_i,
  input  logic                   rst_n_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [2:0]             pprot_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  input  logic [`APB_STRB_W-1:0] pstrb_i,
  output logic                   pready_o,
  output logic [`APB_DATA_W-1:0] prdata_o,
  output logic                   pslverr_o,
  input  logic [`GPIO_W-1:0]     gpio_i,
  output logic [`GPIO_W-1:0]     gpio_o,
  output logic [`GPIO_W-1:0]     gpio_oe_o
);

  // one link per slave port, numbered as in slv_idx_e
  apb_if slv_if [`APB_N_SLV] ();

  // address decode and response mux, no latency of its own
  apb_bus bus_i (
    .pclk_i    (pclk_i),
    .rst_n_i   (rst_n_i),
    .paddr_i   (paddr_i),
    .pprot_i   (pprot_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .slv_o     (slv_if)
  );

  // four scratch words at the bottom of the map
  apb_scratch_regs scratch_i (
    .pclk_i  (pclk_i),
    .rst_n_i (rst_n_i),
    .apb     (slv_if[SLV_SCRATCH])
  );

  // GPIO block, every access takes one wait state
  apb_gpio gpio_i_blk (
    .pclk_i    (pclk_i),
    .rst_n_i   (rst_n_i),
    .apb       (slv_if[SLV_GPIO]),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

/* design/apb_gpio.sv */
//////////////////////////////////////////////////////////////////////
// APB GPIO: output and enable register, synchronized inputs, one wait state
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "apb_sub_macros.svh"

module apb_gpio
  import apb_sub_pkg::*;
(
  input  logic              pclk_i,
  input  logic              rst_n_i,
  apb_if.slave              apb,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic [`GPIO_W-1:0] gpio_oe_o
);

  localparam logic [`APB_ADDR_W-1:0] cfg_ofs = `GPIO_CFG_OFS;
  localparam logic [`APB_ADDR_W-1:0] in_ofs = `GPIO_IN_OFS;

  gpio_cfg_u                cfg_q;
  logic [`GPIO_W-1:0]       in_meta_q;
  logic [`GPIO_W-1:0]       in_sync_q;
  logic                     wait_q;
  logic                     access;
  logic                     done;
  logic [`APB_ADDR_W-1:0]   word_addr;
  logic                     is_cfg;
  logic                     is_in;

  assign access = apb.psel && apb.penable;
  // the second access cycle is the completing one
  assign done   = access && wait_q;

  // register decode on word addresses
  assign word_addr = {apb.paddr[`APB_ADDR_W-1:2], 2'b00};
  assign is_cfg    = (word_addr == cfg_ofs);
  assign is_in     = (word_addr == in_ofs);

  // wait_q marks that the first access cycle has gone by
  // it falls again with the completing cycle, ready for back-to-back transfers
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && !wait_q;
    end
  end

  // configuration word, written through the raw view one byte lane at a time
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.raw <= '0;
    end else if (done && apb.pwrite && is_cfg) begin
      for (int b = 0; b < `APB_STRB_W; b++) begin
        if (apb.pstrb[b]) begin
          cfg_q.raw[8*b +: 8] <= apb.pwdata[8*b +: 8];
        end
      end
    end
  end

  // two-flop synchronizer for the asynchronous input pins
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  // the pins follow the field view of the same register
  assign gpio_o    = cfg_q.f.out;
  assign gpio_oe_o = cfg_q.f.oe;

  assign apb.pready = done;
  // the input word is read-only, a write to it fails and changes nothing
  assign apb.pslverr = done && apb.pwrite && is_in;

  always_comb begin
    apb.prdata = '0;
    if (is_cfg) begin
      apb.prdata = cfg_q.raw;
    end else if (is_in) begin
      apb.prdata[`GPIO_W-1:0] = in_sync_q;
    end
  end

  // ready only after a full access cycle has already passed in this transfer
  a_one_wait : assert property (
    @(posedge pclk_i) disable iff (!rst_n_i)
    apb.pready |-> (access && $past(access))
  );

endmodule

/* design/apb_scratch_regs.sv */
//////////////////////////////////////////////////////////////////////
// APB scratch register bank, four words with byte strobes, no wait states
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "apb_sub_macros.svh"

module apb_scratch_regs (
  input  logic  pclk_i,
  input  logic  rst_n_i,
  apb_if.slave  apb
);

  localparam int idx_w = $clog2(`SCRATCH_WORDS);
  localparam int bytes_per_word = `APB_DATA_W / 8;
  // highest word-aligned offset inside the segment
  localparam logic [`APB_ADDR_W-1:0] last_ofs = (`SCRATCH_WORDS - 1) * bytes_per_word;

  logic [`APB_DATA_W-1:0] words_q [`SCRATCH_WORDS];
  logic [idx_w-1:0]       idx;
  logic                   access;
  logic                   wr_en;

  // word select from the offset, the byte bits below are ignored
  assign idx = apb.paddr[idx_w+1:2];

  // every access phase is also the completing cycle
  assign access = apb.psel && apb.penable;
  assign wr_en  = access && apb.pwrite;

  // the words are visible state, so they start from zero
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < `SCRATCH_WORDS; w++) begin
        words_q[w] <= '0;
      end
    end else if (wr_en) begin
      // each strobe bit guards one byte lane
      for (int b = 0; b < `APB_STRB_W; b++) begin
        if (apb.pstrb[b]) begin
          words_q[idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
        end
      end
    end
  end

  // zero wait states: ready for the whole access phase
  assign apb.pready  = access;
  assign apb.prdata  = words_q[idx];
  // no access to this bank can fail
  assign apb.pslverr = 1'b0;

  // the bus decode must keep the word part of the relative address inside the four words
  a_ofs_range : assert property (
    @(posedge pclk_i) disable iff (!rst_n_i)
    apb.psel |-> ({apb.paddr[`APB_ADDR_W-1:2], 2'b00} <= last_ofs)
  );

endmodule

/* design/apb_bus.sv */
//////////////////////////////////////////////////////////////////////
// APB bus: one master to two slaves with fixed address segments
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "apb_sub_macros.svh"

module apb_bus
  import apb_sub_pkg::*;
(
  input  logic                   pclk_i,
  input  logic                   rst_n_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [2:0]             pprot_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  input  logic [`APB_STRB_W-1:0] pstrb_i,
  output logic                   pready_o,
  output logic [`APB_DATA_W-1:0] prdata_o,
  output logic                   pslverr_o,
  apb_if.master                  slv_o [`APB_N_SLV]
);

  // segment tables, entry i belongs to slave port i (see slv_idx_e)
  localparam logic [`APB_ADDR_W-1:0] seg_begin [`APB_N_SLV] = '{`SCRATCH_BEGIN, `GPIO_BEGIN};
  localparam logic [`APB_ADDR_W-1:0] seg_end [`APB_N_SLV] = '{`SCRATCH_END, `GPIO_END};

  logic [`APB_N_SLV-1:0]   psel_s;
  logic [`APB_N_SLV-1:0]   pready_s;
  logic [`APB_N_SLV-1:0]   pslverr_s;
  logic [`APB_DATA_W-1:0]  prdata_s [`APB_N_SLV];
  slv_idx_e                sel_idx;
  logic                    dec_err;

  for (genvar i = 0; i < `APB_N_SLV; i++) begin : gen_slv
    // only the slave whose segment holds the address sees psel
    assign psel_s[i] = psel_i && (paddr_i >= seg_begin[i]) && (paddr_i <= seg_end[i]);

    // slaves get addresses relative to their own segment base
    assign slv_o[i].paddr   = paddr_i - seg_begin[i];
    assign slv_o[i].pprot   = pprot_i;
    assign slv_o[i].psel    = psel_s[i];
    assign slv_o[i].penable = penable_i;
    assign slv_o[i].pwrite  = pwrite_i;
    assign slv_o[i].pwdata  = pwdata_i;
    assign slv_o[i].pstrb   = pstrb_i;

    // gather the responses so the mux below can index them
    assign pready_s[i]  = slv_o[i].pready;
    assign prdata_s[i]  = slv_o[i].prdata;
    assign pslverr_s[i] = slv_o[i].pslverr;
  end

  // a selected transfer that hits no segment is answered here
  assign dec_err = psel_i && !(|psel_s);

  // turn the one-hot select into a port number for the response mux
  always_comb begin
    sel_idx = SLV_SCRATCH;
    for (int i = 0; i < `APB_N_SLV; i++) begin
      if (psel_s[i]) begin
        sel_idx = slv_idx_e'(i);
      end
    end
  end

  // response back to the master, quiet while psel is low
  always_comb begin
    pready_o  = 1'b0;
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (dec_err) begin
      // completes in the first access cycle, read data stays zero
      pready_o  = 1'b1;
      pslverr_o = 1'b1;
    end else if (psel_i) begin
      pready_o  = pready_s[sel_idx];
      prdata_o  = prdata_s[sel_idx];
      pslverr_o = pslverr_s[sel_idx];
    end
  end

  // the segments must never overlap, so no two slaves are selected together
  a_psel_onehot : assert property (
    @(posedge pclk_i) disable iff (!rst_n_i) $onehot0(psel_s)
  );

  // the master must not enter the access phase without a selected transfer
  a_penable_psel : assert property (
    @(posedge pclk_i) disable iff (!rst_n_i) penable_i |-> psel_i
  );

  // a stalled access keeps its whole request until a slave answers
  a_req_stable : assert property (
    @(posedge pclk_i) disable iff (!rst_n_i)
    (psel_i && penable_i && !pready_o) |=>
      (psel_i && penable_i && $stable(paddr_i) && $stable(pprot_i) &&
       $stable(pwrite_i) && $stable(pwdata_i) && $stable(pstrb_i))
  );

endmodule

/* design/apb_if.sv */
//////////////////////////////////////////////////////////////////////
// APB link between the bus decoder and one slave
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "apb_sub_macros.svh"

interface apb_if;

  // request, driven by the bus
  logic [`APB_ADDR_W-1:0] paddr;
  logic [2:0]             pprot;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_DATA_W-1:0] pwdata;
  logic [`APB_STRB_W-1:0] pstrb;

  // response, driven by the slave
  // prdata and pslverr only mean something in the cycle with pready high
  logic                   pready;
  logic [`APB_DATA_W-1:0] prdata;
  logic                   pslverr;

  // bus side of the link
  modport master (
    output paddr, pprot, psel, penable, pwrite, pwdata, pstrb,
    input  pready, prdata, pslverr
  );

  // peripheral side of the link
  modport slave (
    input  paddr, pprot, psel, penable, pwrite, pwdata, pstrb,
    output pready, prdata, pslverr
  );

endinterface

/* design/apb_sub_pkg.sv */
//////////////////////////////////////////////////////////////////////
// APB subsystem types: GPIO configuration word and slave port names
//////////////////////////////////////////////////////////////////////
package apb_sub_pkg;

  `include "apb_sub_macros.svh"

  // field view of the GPIO configuration word
  // the output enables sit in the upper half, the output levels in the lower half
  typedef struct packed {
    logic [`GPIO_W-1:0] oe;
    logic [`GPIO_W-1:0] out;
  } gpio_cfg_t;

  // the bus side sees a plain word with byte lanes, the pins see the fields
  typedef union packed {
    logic [`APB_DATA_W-1:0] raw;
    gpio_cfg_t              f;
  } gpio_cfg_u;

  // slave port numbering behind the bus
  // the order must follow the address segment tables in the bus
  typedef enum logic [$clog2(`APB_N_SLV)-1:0] {
    SLV_SCRATCH = 0,
    SLV_GPIO    = 1
  } slv_idx_e;

endpackage

/* design/apb_sub_macros.svh */
//////////////////////////////////////////////////////////////////////
// APB peripheral subsystem constants: bus widths and fixed address map
//////////////////////////////////////////////////////////////////////
`ifndef APB_SUB_MACROS_SVH
`define APB_SUB_MACROS_SVH

// APB bus widths, one strobe bit per data byte
`define APB_ADDR_W 32
`define APB_DATA_W 32
`define APB_STRB_W 4

// number of slave ports behind the bus
`define APB_N_SLV 2

// inclusive address segments, the bus subtracts the begin value
`define SCRATCH_BEGIN 32'h0000_0000
`define SCRATCH_END   32'h0000_000f
`define GPIO_BEGIN    32'h0000_1000
`define GPIO_END      32'h0000_1007

// slave geometry and register offsets inside the GPIO segment
`define SCRATCH_WORDS 4
`define GPIO_W        16
`define GPIO_CFG_OFS  32'h0000_0000
`define GPIO_IN_OFS   32'h0000_0004

`endif
